// File: tb/mipsCore_golden.txt
# I <byte address> <instruction word>   D <byte address> <initial data word>
# W <pc> <register> <expected write data> in retirement order
I 00000000 3c011234
I 00000004 34215678
I 00000008 2402fffd
I 0000000c 24030064
I 00000010 00222021
I 00000014 00832823
I 00000018 00a13024
I 0000001c 00c33825
I 00000020 00e54026
I 00000024 0048482a
I 00000028 0102502a
I 0000002c 24600005
I 00000030 240b0040
I 00000034 ad610004
I 00000038 8d6c0004
I 0000003c 01836821
I 00000040 8c0e0080
I 00000044 15c30003
I 00000048 240f0001
I 0000004c 11e90002
I 00000050 24100016
I 00000054 24110bad
I 00000058 08000019
I 0000005c 24120018
I 00000060 24130bad
I 00000064 0250a021
I 00000068 0800001a
I 0000006c 00000000
D 00000080 00000064
W 00000000 01 12340000
W 00000004 01 12345678
W 00000008 02 fffffffd
W 0000000c 03 00000064
W 00000010 04 12345675
W 00000014 05 12345611
W 00000018 06 12345610
W 0000001c 07 12345674
W 00000020 08 00000065
W 00000024 09 00000001
W 00000028 0a 00000000
W 00000030 0b 00000040
W 00000038 0c 12345678
W 0000003c 0d 123456dc
W 00000040 0e 00000064
W 00000048 0f 00000001
W 00000050 10 00000016
W 0000005c 12 00000018
W 00000064 14 0000002e

// File: verilog.f
+incdir+rtl
rtl/mipsPkg.sv
rtl/fetchStage.sv
rtl/regFile.sv
rtl/decodeStage.sv
rtl/executeStage.sv
rtl/memoryStage.sv
rtl/hazardUnit.sv
rtl/mipsCore.sv
tb/tbMemory.sv
tb/tbMipsCore.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module tbMipsCore
out=$(./obj_dir/VtbMipsCore)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -q "STATUS: PASS"

// File: tb/tbMipsCore.sv
`timescale 1ns/1ps
`default_nettype none
`include "mipsCore_config.svh"

module tbMipsCore;
	import mipsPkg::*;

	localparam int MAX_ENTRIES = 256;
	// watch for stray writebacks after the last expected one
	localparam int DRAIN_CYCLES = 12;

	logic aclk;
	logic rstN;
	wordT instAddr;
	wordT instData;
	dataReqT dataReq;
	wordT dataRdata;
	wbTraceT debugWb;

	wordT expPc [MAX_ENTRIES];
	wordT expReg [MAX_ENTRIES];
	wordT expData [MAX_ENTRIES];
	int expCount;
	int expIdx;
	int instCount;
	int cycleCount;
	int cycleLimit;
	int checkCount;
	int errorCount;

	mipsCore i_dut (
		.aclk_i      (aclk),
		.rstN_i      (rstN),
		.instAddr_o  (instAddr),
		.instData_i  (instData),
		.dataReq_o   (dataReq),
		.dataRdata_i (dataRdata),
		.debugWb_o   (debugWb)
	);

	tbMemory i_mem (
		.aclk_i      (aclk),
		.instAddr_i  (instAddr),
		.instData_o  (instData),
		.dataReq_i   (dataReq),
		.dataRdata_o (dataRdata)
	);

	initial begin
		aclk = 1'b0;
		forever #5 aclk = ~aclk;
	end

	task automatic compareWord(input string name, input wordT expected, input wordT actual);
		checkCount++;
		assert (actual == expected) else begin
			$display("[ERROR] %0t %s expected %h actual %h", $time, name, expected, actual);
			errorCount++;
		end
	endtask

	task automatic skipLine(input int fd);
		int ch;
		ch = 0;
		while (ch != 8'h0a && ch != -1) begin
			ch = $fgetc(fd);
		end
	endtask

	// I addr word, D addr word, W pc reg data
	task automatic readGolden();
		int fd;
		int fields;
		logic [63:0] tag;
		wordT a;
		wordT b;
		wordT c;
		fd = $fopen("tb/mipsCore_golden.txt", "r");
		if (fd == 0) begin
			$display("cannot open the golden file tb/mipsCore_golden.txt");
			errorCount++;
			return;
		end
		tag = '0;
		while ($fscanf(fd, "%s", tag) == 1) begin
			if (tag == "#") begin
				skipLine(fd);
			end else if (tag == "I" || tag == "D") begin
				fields = $fscanf(fd, "%h %h", a, b);
				if (fields != 2) begin
					$display("golden file holds an I or D entry without address and word");
					errorCount++;
				end else if (tag == "I") begin
					i_mem.loadInstr(a, b);
					instCount++;
				end else begin
					i_mem.loadData(a, b);
				end
			end else if (tag == "W") begin
				fields = $fscanf(fd, "%h %h %h", a, b, c);
				if (fields != 3 || expCount >= MAX_ENTRIES) begin
					$display("golden file holds a W entry that cannot be used");
					errorCount++;
				end else begin
					expPc[expCount] = a;
					expReg[expCount] = b;
					expData[expCount] = c;
					expCount++;
				end
			end else begin
				$display("golden file holds an entry that is not I, D or W");
				errorCount++;
				skipLine(fd);
			end
			tag = '0;
		end
		$fclose(fd);
	endtask

	// trace checker sampled on the rising edge
	always @(posedge aclk) begin
		if (rstN) begin
			cycleCount++;
			if (debugWb.valid) begin
				assert (expIdx < expCount) else begin
					$display("writeback of register %0d at pc %h came after the last expected one",
						debugWb.regNum, debugWb.pc);
					errorCount++;
				end
				if (expIdx < expCount) begin
					compareWord("debugWb_o.pc", expPc[expIdx], debugWb.pc);
					compareWord("debugWb_o.regNum", expReg[expIdx], wordT'(debugWb.regNum));
					compareWord("debugWb_o.data", expData[expIdx], debugWb.data);
					expIdx++;
				end
			end
		end
	end

	initial begin
		rstN = 1'b0;
		expCount = 0;
		expIdx = 0;
		instCount = 0;
		cycleCount = 0;
		checkCount = 0;
		errorCount = 0;
		i_mem.fillPatterns();
		readGolden();
		cycleLimit = 8 * instCount + 20;
		repeat (5) begin
			@(negedge aclk);
			compareWord("debugWb_o.valid", '0, wordT'(debugWb.valid));
			compareWord("dataReq_o.en", '0, wordT'(dataReq.en));
		end
		rstN = 1'b1;
		compareWord("instAddr_o", `MIPS_RESET_PC, instAddr);
		@(negedge aclk);
		compareWord("debugWb_o.valid", '0, wordT'(debugWb.valid));
		compareWord("dataReq_o.en", '0, wordT'(dataReq.en));
		while (expIdx < expCount && cycleCount < cycleLimit) begin
			@(negedge aclk);
		end
		if (expIdx < expCount) begin
			$display("timeout after %0d cycles with %0d of %0d expected writebacks seen",
				cycleCount, expIdx, expCount);
			errorCount++;
		end else begin
			repeat (DRAIN_CYCLES) @(negedge aclk);
		end
		$display("checks %0d, errors %0d, writebacks %0d of %0d",
			checkCount, errorCount, expIdx, expCount);
		if (errorCount == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: tb/tbMemory.sv
`timescale 1ns/1ps
`default_nettype none

module tbMemory #(
	parameter int DEPTH = 256
) (
	input  wire logic             aclk_i,
	input  wire mipsPkg::wordT    instAddr_i,
	output mipsPkg::wordT         instData_o,
	input  wire mipsPkg::dataReqT dataReq_i,
	output mipsPkg::wordT         dataRdata_o
);
	import mipsPkg::*;

	localparam int IDX_W = $clog2(DEPTH);

	wordT rom [DEPTH];
	wordT ram [DEPTH];

	// word addressed and upper address bits alias
	assign instData_o = rom[instAddr_i[IDX_W+1:2]];
	assign dataRdata_o = (dataReq_i.en && !dataReq_i.we) ? ram[dataReq_i.addr[IDX_W+1:2]] : '0;

	// stores land on the rising edge
	always @(posedge aclk_i) begin
		if (dataReq_i.en && dataReq_i.we) begin
			ram[dataReq_i.addr[IDX_W+1:2]] = dataReq_i.wdata;
		end
	end

	// unloaded words carry their own byte address
	task automatic fillPatterns();
		for (int i = 0; i < DEPTH; i++) begin
			rom[i] = wordT'(i * 4) ^ 32'hbadc_0de0;
			ram[i] = wordT'(i * 4) ^ 32'h5eed_0000;
		end
	endtask

	task automatic loadInstr(input wordT addr, input wordT data);
		rom[addr[IDX_W+1:2]] = data;
	endtask

	task automatic loadData(input wordT addr, input wordT data);
		ram[addr[IDX_W+1:2]] = data;
	endtask

endmodule

`default_nettype wire

// File: rtl/mipsCore.sv
`timescale 1ns/1ps
`default_nettype none

module mipsCore (
	input  wire logic          aclk_i,
	input  wire logic          rstN_i,
	output mipsPkg::wordT      instAddr_o,
	input  wire mipsPkg::wordT instData_i,
	output mipsPkg::dataReqT   dataReq_o,
	input  wire mipsPkg::wordT dataRdata_i,
	output mipsPkg::wbTraceT   debugWb_o
);
	import mipsPkg::*;

	ifIdT ifId;
	idExT idEx;
	exMemT exMem;
	memWbT memWb;
	regAddrT rsD;
	regAddrT rtD;
	logic isBranch;
	logic redirect;
	wordT target;
	logic stallFD;
	fwdSelE fwdA;
	fwdSelE fwdB;
	logic fwdBranchA;
	logic fwdBranchB;

	fetchStage i_fetch (
		.aclk_i     (aclk_i),
		.rstN_i     (rstN_i),
		.stall_i    (stallFD),
		.redirect_i (redirect),
		.target_i   (target),
		.instData_i (instData_i),
		.instAddr_o (instAddr_o),
		.ifId_o     (ifId)
	);

	decodeStage i_decode (
		.aclk_i       (aclk_i),
		.rstN_i       (rstN_i),
		.ifId_i       (ifId),
		.stall_i      (stallFD),
		.fwdBranchA_i (fwdBranchA),
		.fwdBranchB_i (fwdBranchB),
		.memResult_i  (exMem.aluResult),
		.memWb_i      (memWb),
		.rs_o         (rsD),
		.rt_o         (rtD),
		.isBranch_o   (isBranch),
		.redirect_o   (redirect),
		.target_o     (target),
		.idEx_o       (idEx)
	);

	executeStage i_execute (
		.aclk_i      (aclk_i),
		.rstN_i      (rstN_i),
		.idEx_i      (idEx),
		.fwdA_i      (fwdA),
		.fwdB_i      (fwdB),
		.memResult_i (exMem.aluResult),
		.wbResult_i  (memWb.result),
		.exMem_o     (exMem)
	);

	memoryStage i_memory (
		.aclk_i      (aclk_i),
		.rstN_i      (rstN_i),
		.exMem_i     (exMem),
		.dataRdata_i (dataRdata_i),
		.dataReq_o   (dataReq_o),
		.memWb_o     (memWb)
	);

	hazardUnit i_hazard (
		.rsD_i        (rsD),
		.rtD_i        (rtD),
		.isBranch_i   (isBranch),
		.idEx_i       (idEx),
		.exMem_i      (exMem),
		.memWb_i      (memWb),
		.stallFD_o    (stallFD),
		.fwdA_o       (fwdA),
		.fwdB_o       (fwdB),
		.fwdBranchA_o (fwdBranchA),
		.fwdBranchB_o (fwdBranchB)
	);

	// only visible register writes are traced
	always_comb begin
		debugWb_o.valid = memWb.valid && memWb.regWrite && (memWb.dest != '0);
		debugWb_o.pc = memWb.pc;
		debugWb_o.regNum = memWb.dest;
		debugWb_o.data = memWb.result;
	end

endmodule

`default_nettype wire

// File: rtl/hazardUnit.sv
`timescale 1ns/1ps
`default_nettype none

module hazardUnit (
	input  wire mipsPkg::regAddrT rsD_i,
	input  wire mipsPkg::regAddrT rtD_i,
	input  wire logic             isBranch_i,
	input  wire mipsPkg::idExT    idEx_i,
	input  wire mipsPkg::exMemT   exMem_i,
	input  wire mipsPkg::memWbT   memWb_i,
	output logic                  stallFD_o,
	output mipsPkg::fwdSelE       fwdA_o,
	output mipsPkg::fwdSelE       fwdB_o,
	output logic                  fwdBranchA_o,
	output logic                  fwdBranchB_o
);
	import mipsPkg::*;

	logic memFwdOk;
	logic wbFwdOk;
	logic exHit;
	logic memLoadHit;

	// MEM wins over WB when both hold the register
	function automatic fwdSelE pickSource(input regAddrT src, input logic memOk,
		input regAddrT memDest, input logic wbOk, input regAddrT wbDest);
		fwdSelE sel;
		sel = FWD_REG;
		if (memOk && memDest == src)
			sel = FWD_MEM;
		else if (wbOk && wbDest == src)
			sel = FWD_WB;
		return sel;
	endfunction

	// a load in MEM has no result yet
	assign memFwdOk = exMem_i.valid && exMem_i.regWrite && !exMem_i.memRead
		&& (exMem_i.dest != '0);
	assign wbFwdOk = memWb_i.valid && memWb_i.regWrite && (memWb_i.dest != '0);

	assign fwdA_o = pickSource(idEx_i.rs, memFwdOk, exMem_i.dest, wbFwdOk, memWb_i.dest);
	assign fwdB_o = pickSource(idEx_i.rt, memFwdOk, exMem_i.dest, wbFwdOk, memWb_i.dest);

	assign fwdBranchA_o = memFwdOk && (exMem_i.dest == rsD_i);
	assign fwdBranchB_o = memFwdOk && (exMem_i.dest == rtD_i);

	assign exHit = idEx_i.valid && idEx_i.regWrite && (idEx_i.dest != '0)
		&& (idEx_i.dest == rsD_i || idEx_i.dest == rtD_i);
	assign memLoadHit = exMem_i.valid && exMem_i.memRead && (exMem_i.dest != '0)
		&& (exMem_i.dest == rsD_i || exMem_i.dest == rtD_i);

	// load-use, or branch waiting on EX, or on a load still in MEM
	assign stallFD_o = (exHit && idEx_i.memRead) || (isBranch_i && exHit)
		|| (isBranch_i && memLoadHit);

endmodule

`default_nettype wire

// File: rtl/memoryStage.sv
`timescale 1ns/1ps
`default_nettype none

module memoryStage (
	input  wire logic           aclk_i,
	input  wire logic           rstN_i,
	input  wire mipsPkg::exMemT exMem_i,
	input  wire mipsPkg::wordT  dataRdata_i,
	output mipsPkg::dataReqT    dataReq_o,
	output mipsPkg::memWbT      memWb_o
);
	import mipsPkg::*;

	wordT result;

	always_comb begin
		dataReq_o.en = exMem_i.valid && (exMem_i.memRead || exMem_i.memWrite);
		dataReq_o.we = exMem_i.memWrite;
		dataReq_o.addr = exMem_i.aluResult;
		dataReq_o.wdata = exMem_i.storeData;
	end

	// read data is back in the same cycle
	assign result = exMem_i.memRead ? dataRdata_i : exMem_i.aluResult;

	always_ff @(posedge aclk_i) begin
		if (!rstN_i) begin
			memWb_o <= '0;
		end else begin
			memWb_o.valid <= exMem_i.valid;
			memWb_o.regWrite <= exMem_i.regWrite;
			memWb_o.dest <= exMem_i.dest;
			memWb_o.result <= result;
			memWb_o.pc <= exMem_i.pc;
		end
	end

endmodule

`default_nettype wire

// File: rtl/executeStage.sv
`timescale 1ns/1ps
`default_nettype none

module executeStage (
	input  wire logic            aclk_i,
	input  wire logic            rstN_i,
	input  wire mipsPkg::idExT   idEx_i,
	input  wire mipsPkg::fwdSelE fwdA_i,
	input  wire mipsPkg::fwdSelE fwdB_i,
	input  wire mipsPkg::wordT   memResult_i,
	input  wire mipsPkg::wordT   wbResult_i,
	output mipsPkg::exMemT       exMem_o
);
	import mipsPkg::*;

	wordT opA;
	wordT rtFwd;
	wordT opB;
	wordT aluResult;

	always_comb begin
		case (fwdA_i)
			FWD_MEM: opA = memResult_i;
			FWD_WB:  opA = wbResult_i;
			default: opA = idEx_i.rsVal;
		endcase
		case (fwdB_i)
			FWD_MEM: rtFwd = memResult_i;
			FWD_WB:  rtFwd = wbResult_i;
			default: rtFwd = idEx_i.rtVal;
		endcase
	end

	assign opB = idEx_i.useImm ? idEx_i.imm : rtFwd;

	always_comb begin
		case (idEx_i.aluOp)
			ALU_ADD: aluResult = opA + opB;
			ALU_SUB: aluResult = opA - opB;
			ALU_AND: aluResult = opA & opB;
			ALU_OR:  aluResult = opA | opB;
			ALU_XOR: aluResult = opA ^ opB;
			ALU_SLT: aluResult = {31'b0, $signed(opA) < $signed(opB)};
			ALU_LUI: aluResult = {opB[15:0], 16'h0000};
			default: aluResult = '0;
		endcase
	end

	always_ff @(posedge aclk_i) begin
		if (!rstN_i) begin
			exMem_o <= '0;
		end else begin
			exMem_o.valid <= idEx_i.valid;
			exMem_o.memRead <= idEx_i.memRead;
			exMem_o.memWrite <= idEx_i.memWrite;
			exMem_o.regWrite <= idEx_i.regWrite;
			exMem_o.dest <= idEx_i.dest;
			exMem_o.aluResult <= aluResult;
			// store data needs the forwarded rt too
			exMem_o.storeData <= rtFwd;
			exMem_o.pc <= idEx_i.pc;
		end
	end

endmodule

`default_nettype wire

// File: rtl/decodeStage.sv
`timescale 1ns/1ps
`default_nettype none
`include "mipsCore_config.svh"

module decodeStage (
	input  wire logic            aclk_i,
	input  wire logic            rstN_i,
	input  wire mipsPkg::ifIdT   ifId_i,
	input  wire logic            stall_i,
	input  wire logic            fwdBranchA_i,
	input  wire logic            fwdBranchB_i,
	input  wire mipsPkg::wordT   memResult_i,
	input  wire mipsPkg::memWbT  memWb_i,
	output mipsPkg::regAddrT     rs_o,
	output mipsPkg::regAddrT     rt_o,
	output logic                 isBranch_o,
	output logic                 redirect_o,
	output mipsPkg::wordT        target_o,
	output mipsPkg::idExT        idEx_o
);
	import mipsPkg::*;

	logic [5:0] opcode;
	logic [5:0] funct;
	logic [15:0] imm16;
	regAddrT rs;
	regAddrT rt;
	regAddrT rd;
	wordT rsVal;
	wordT rtVal;
	wordT cmpA;
	wordT cmpB;
	wordT pc;
	wordT branchTarget;
	wordT jumpTarget;
	logic usesRs;
	logic usesRt;
	logic isBne;
	logic isJump;
	logic taken;
	idExT idExNext;

	assign opcode = ifId_i.instr[31:26];
	assign rs = ifId_i.instr[25:21];
	assign rt = ifId_i.instr[20:16];
	assign rd = ifId_i.instr[15:11];
	assign imm16 = ifId_i.instr[15:0];
	assign funct = ifId_i.instr[5:0];
	assign pc = ifId_i.pcPlus4 - `MIPS_XLEN'd4;

	regFile i_regFile (
		.aclk_i   (aclk_i),
		.rstN_i   (rstN_i),
		.raddrA_i (rs),
		.raddrB_i (rt),
		.we_i     (memWb_i.valid && memWb_i.regWrite),
		.waddr_i  (memWb_i.dest),
		.wdata_i  (memWb_i.result),
		.rdataA_o (rsVal),
		.rdataB_o (rtVal)
	);

	always_comb begin
		idExNext = '0;
		idExNext.valid = 1'b1;
		idExNext.rsVal = rsVal;
		idExNext.rtVal = rtVal;
		idExNext.pc = pc;
		usesRs = 1'b0;
		usesRt = 1'b0;
		isBranch_o = 1'b0;
		isBne = 1'b0;
		isJump = 1'b0;
		case (opcode)
			`OP_RTYPE: begin
				usesRs = 1'b1;
				usesRt = 1'b1;
				idExNext.dest = rd;
				idExNext.regWrite = 1'b1;
				case (funct)
					`FN_ADDU: idExNext.aluOp = ALU_ADD;
					`FN_SUBU: idExNext.aluOp = ALU_SUB;
					`FN_AND:  idExNext.aluOp = ALU_AND;
					`FN_OR:   idExNext.aluOp = ALU_OR;
					`FN_XOR:  idExNext.aluOp = ALU_XOR;
					`FN_SLT:  idExNext.aluOp = ALU_SLT;
					// nop and anything unsupported
					default:  idExNext.regWrite = 1'b0;
				endcase
			end
			`OP_ADDIU, `OP_LW, `OP_SW: begin
				usesRs = 1'b1;
				usesRt = (opcode == `OP_SW);
				idExNext.aluOp = ALU_ADD;
				idExNext.useImm = 1'b1;
				idExNext.imm = {{16{imm16[15]}}, imm16};
				idExNext.dest = rt;
				idExNext.regWrite = (opcode != `OP_SW);
				idExNext.memRead = (opcode == `OP_LW);
				idExNext.memWrite = (opcode == `OP_SW);
			end
			`OP_ORI, `OP_LUI: begin
				usesRs = (opcode == `OP_ORI);
				idExNext.aluOp = (opcode == `OP_ORI) ? ALU_OR : ALU_LUI;
				idExNext.useImm = 1'b1;
				idExNext.imm = {16'h0000, imm16};
				idExNext.dest = rt;
				idExNext.regWrite = 1'b1;
			end
			`OP_BEQ, `OP_BNE: begin
				usesRs = 1'b1;
				usesRt = 1'b1;
				isBranch_o = 1'b1;
				isBne = (opcode == `OP_BNE);
			end
			`OP_J: isJump = 1'b1;
			// unknown opcodes go down the pipe as bubbles
			default: idExNext.valid = 1'b0;
		endcase
		// unused fields read as r0 so they never match a hazard
		idExNext.rs = usesRs ? rs : '0;
		idExNext.rt = usesRt ? rt : '0;
	end

	assign rs_o = idExNext.rs;
	assign rt_o = idExNext.rt;

	// comparator takes the MEM stage ALU result when forwarded
	assign cmpA = fwdBranchA_i ? memResult_i : rsVal;
	assign cmpB = fwdBranchB_i ? memResult_i : rtVal;
	assign taken = isBranch_o && ((cmpA == cmpB) != isBne);

	assign branchTarget = ifId_i.pcPlus4 + {{14{imm16[15]}}, imm16, 2'b00};
	assign jumpTarget = {ifId_i.pcPlus4[31:28], ifId_i.instr[25:0], 2'b00};

	assign redirect_o = !stall_i && (isJump || taken);
	assign target_o = isJump ? jumpTarget : branchTarget;

	always_ff @(posedge aclk_i) begin
		if (!rstN_i) begin
			idEx_o <= '0;
		end else if (stall_i) begin
			idEx_o <= '0;
		end else begin
			idEx_o <= idExNext;
		end
	end

endmodule

`default_nettype wire

// File: rtl/regFile.sv
`timescale 1ns/1ps
`default_nettype none
`include "mipsCore_config.svh"

module regFile (
	input  wire logic             aclk_i,
	input  wire logic             rstN_i,
	input  wire mipsPkg::regAddrT raddrA_i,
	input  wire mipsPkg::regAddrT raddrB_i,
	input  wire logic             we_i,
	input  wire mipsPkg::regAddrT waddr_i,
	input  wire mipsPkg::wordT    wdata_i,
	output mipsPkg::wordT         rdataA_o,
	output mipsPkg::wordT         rdataB_o
);
	import mipsPkg::*;

	wordT regs [`MIPS_REG_COUNT];
	logic doWrite;

	// r0 is never stored
	assign doWrite = rstN_i && we_i && (waddr_i != '0);

	always_ff @(posedge aclk_i) begin
		if (doWrite) begin
			regs[waddr_i] <= wdata_i;
		end
	end

	// write-through so decode sees the value retiring this cycle
	assign rdataA_o = (raddrA_i == '0) ? '0 :
		(doWrite && waddr_i == raddrA_i) ? wdata_i : regs[raddrA_i];
	assign rdataB_o = (raddrB_i == '0) ? '0 :
		(doWrite && waddr_i == raddrB_i) ? wdata_i : regs[raddrB_i];

endmodule

`default_nettype wire

// File: rtl/fetchStage.sv
`timescale 1ns/1ps
`default_nettype none
`include "mipsCore_config.svh"

module fetchStage (
	input  wire logic          aclk_i,
	input  wire logic          rstN_i,
	input  wire logic          stall_i,
	input  wire logic          redirect_i,
	input  wire mipsPkg::wordT target_i,
	input  wire mipsPkg::wordT instData_i,
	output mipsPkg::wordT      instAddr_o,
	output mipsPkg::ifIdT      ifId_o
);
	import mipsPkg::*;

	wordT pc;
	wordT pcPlus4;
	wordT pcNext;

	assign pcPlus4 = pc + `MIPS_XLEN'd4;

	// decode redirect lands after the delay slot is fetched
	assign pcNext = redirect_i ? target_i : pcPlus4;

	assign instAddr_o = pc;

	always_ff @(posedge aclk_i) begin
		if (!rstN_i) begin
			pc <= `MIPS_RESET_PC;
			ifId_o <= '0;
		end else if (!stall_i) begin
			pc <= pcNext;
			ifId_o.instr <= instData_i;
			ifId_o.pcPlus4 <= pcPlus4;
		end
	end

endmodule

`default_nettype wire

// File: rtl/mipsPkg.sv
`default_nettype none
`include "mipsCore_config.svh"

package mipsPkg;

	typedef logic [$clog2(`MIPS_REG_COUNT)-1:0] regAddrT;
	typedef logic [`MIPS_XLEN-1:0] wordT;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_LUI
	} aluOpE;

	// operand source for execute
	typedef enum logic [1:0] {
		FWD_REG,
		FWD_MEM,
		FWD_WB
	} fwdSelE;

	typedef struct packed {
		wordT instr;
		wordT pcPlus4;
	} ifIdT;

	typedef struct packed {
		logic    valid;
		aluOpE   aluOp;
		logic    useImm;
		logic    memRead;
		logic    memWrite;
		logic    regWrite;
		regAddrT rs;
		regAddrT rt;
		regAddrT dest;
		wordT    rsVal;
		wordT    rtVal;
		wordT    imm;
		wordT    pc;
	} idExT;

	typedef struct packed {
		logic    valid;
		logic    memRead;
		logic    memWrite;
		logic    regWrite;
		regAddrT dest;
		wordT    aluResult;
		wordT    storeData;
		wordT    pc;
	} exMemT;

	typedef struct packed {
		logic    valid;
		logic    regWrite;
		regAddrT dest;
		wordT    result;
		wordT    pc;
	} memWbT;

	typedef struct packed {
		logic en;
		logic we;
		wordT addr;
		wordT wdata;
	} dataReqT;

	typedef struct packed {
		logic    valid;
		wordT    pc;
		regAddrT regNum;
		wordT    data;
	} wbTraceT;

endpackage

`default_nettype wire

// File: rtl/mipsCore_config.svh
`ifndef MIPSCORE_CONFIG_SVH
`define MIPSCORE_CONFIG_SVH

`define MIPS_XLEN      32
`define MIPS_REG_COUNT 32
`define MIPS_RESET_PC  32'h0000_0000

// primary opcodes
`define OP_RTYPE 6'h00
`define OP_J     6'h02
`define OP_BEQ   6'h04
`define OP_BNE   6'h05
`define OP_ADDIU 6'h09
`define OP_ORI   6'h0d
`define OP_LUI   6'h0f
`define OP_LW    6'h23
`define OP_SW    6'h2b

// funct field of R-type
`define FN_ADDU 6'h21
`define FN_SUBU 6'h23
`define FN_AND  6'h24
`define FN_OR   6'h25
`define FN_XOR  6'h26
`define FN_SLT  6'h2a

`endif
